// File: axi_bridge_sva.sv
/* bound assertions: AR and AW hold until ready, read queue occupancy limit */
`timescale 1ns/1ns
`default_nettype none

module axi_bridge_sva
    import axi_pkg::*;
    import bridge_pkg::*;
(
    input logic              clk,
    input logic              rst,
    input axi_ar_t           i_ar,
    input logic              i_arready,
    input axi_aw_t           i_aw,
    input logic              i_awready,
    input logic [RQ_IDX_W:0] i_occupancy
);

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        i_ar.valid && !i_arready |=> $stable(i_ar))
        else $error("AR valid or payload changed before arready");

    occupancy_limit: assert property (@(posedge clk) disable iff (rst)
        i_occupancy <= (RQ_IDX_W + 1)'(RQ_DEPTH))
        else $error("more reads outstanding than queue slots");

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        i_aw.valid && !i_awready |=> i_aw.valid)
        else $error("awvalid dropped before awready");

endmodule

bind read_queue axi_bridge_sva i_rq_sva (
    .clk(clk), .rst(rst), .i_ar(o_ar), .i_arready(i_arready),
    .i_aw('0), .i_awready(1'b1), .i_occupancy(alloc_ptr - retire_ptr)
);

bind write_buffer axi_bridge_sva i_wb_sva (
    .clk(clk), .rst(rst), .i_ar('0), .i_arready(1'b1),
    .i_aw(o_aw), .i_awready(i_awready), .i_occupancy('0)
);

`default_nettype wire

// File: axi_bridge_top.sv
/* processor to AXI3 bridge: arbiter, read queue and write buffer */
`timescale 1ns/1ns
`default_nettype none

module axi_bridge_top
    import axi_pkg::*;
    import bridge_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // processor side
    input  ifetch_req_t i_ifetch,
    input  dmem_req_t   i_dmem,
    output port_rsp_t   o_i_rsp,
    output port_rsp_t   o_d_rsp,
    output logic        o_i_stall,
    output logic        o_d_stall,
    // axi read
    output axi_ar_t     o_ar,
    input  logic        i_arready,
    input  axi_r_t      i_r,
    output logic        o_rready,
    // axi write
    output axi_aw_t     o_aw,
    input  logic        i_awready,
    output axi_w_t      o_w,
    input  logic        i_wready,
    input  axi_b_t      i_b,
    output logic        o_bready
);

    rd_req_t  rd_req;
    logic     rq_full;
    wr_pend_t wr_pend;
    logic     wr_busy;

    // responses are never back-pressured
    assign o_rready = 1'b1;
    assign o_bready = 1'b1;

    read_arbiter i_read_arbiter (
        .clk       (clk),
        .rst       (rst),
        .i_ifetch  (i_ifetch),
        .i_dmem    (i_dmem),
        .i_full    (rq_full),
        .i_wr_pend (wr_pend),
        .i_wr_busy (wr_busy),
        .o_rd_req  (rd_req),
        .o_i_stall (o_i_stall),
        .o_d_stall (o_d_stall)
    );

    read_queue i_read_queue (
        .clk       (clk),
        .rst       (rst),
        .i_rd_req  (rd_req),
        .o_full    (rq_full),
        .o_ar      (o_ar),
        .i_arready (i_arready),
        .i_r       (i_r),
        .o_i_rsp   (o_i_rsp),
        .o_d_rsp   (o_d_rsp)
    );

    write_buffer i_write_buffer (
        .clk       (clk),
        .rst       (rst),
        .i_dmem    (i_dmem),
        .o_wr_pend (wr_pend),
        .o_wr_busy (wr_busy),
        .o_aw      (o_aw),
        .i_awready (i_awready),
        .o_w       (o_w),
        .i_wready  (i_wready),
        .i_b       (i_b)
    );

endmodule

`default_nettype wire

// File: axi_pkg.sv
/* AXI3 master channel definitions: widths, size and burst codes,
   and one packed struct per channel */
`default_nettype none

package axi_pkg;

    ////////////////////
    // widths

    localparam int AXI_DATA_W  = 64;
    localparam int AXI_ADDR_W  = 32;
    localparam int AXI_ID_W    = 4;
    localparam int AXI_STRB_W  = AXI_DATA_W / 8;
    localparam int AXI_LEN_W   = 4;
    localparam int AXI_SIZE_W  = 3;
    localparam int AXI_BURST_W = 2;
    localparam int AXI_RESP_W  = 2;

    // byte offset bits inside one bus word
    localparam int AXI_BYTE_OFS_W = $clog2(AXI_STRB_W);

    localparam logic [AXI_BURST_W-1:0] AXI_BURST_INCR = 2'b01;

    ////////////////////
    // channels, ready travels on its own wire

    typedef struct packed {
        logic                   valid;
        logic [AXI_ID_W-1:0]    id;
        logic [AXI_ADDR_W-1:0]  addr;
        logic [AXI_LEN_W-1:0]   len;
        logic [AXI_SIZE_W-1:0]  size;
        logic [AXI_BURST_W-1:0] burst;
    } axi_ar_t;

    typedef struct packed {
        logic                  valid;
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_RESP_W-1:0] resp;
        logic                  last;
    } axi_r_t;

    typedef struct packed {
        logic                   valid;
        logic [AXI_ID_W-1:0]    id;
        logic [AXI_ADDR_W-1:0]  addr;
        logic [AXI_LEN_W-1:0]   len;
        logic [AXI_SIZE_W-1:0]  size;
        logic [AXI_BURST_W-1:0] burst;
    } axi_aw_t;

    typedef struct packed {
        logic                  valid;
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_STRB_W-1:0] strb;
        logic                  last;
    } axi_w_t;

    typedef struct packed {
        logic                  valid;
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_RESP_W-1:0] resp;
    } axi_b_t;

endpackage

`default_nettype wire

// File: bridge_pkg.sv
/* processor side of the bridge: read queue sizing, slot index,
   port request and response structs, internal request structs */
`default_nettype none

package bridge_pkg;

    import axi_pkg::*;

    ////////////////////
    // read queue

    // slot index doubles as the AXI read id
    localparam int RQ_DEPTH = 4;
    localparam int RQ_IDX_W = $clog2(RQ_DEPTH);

    // fetches always read one full bus word
    localparam logic [AXI_SIZE_W-1:0] SIZE_DWORD = 3'd3;

    typedef logic [RQ_IDX_W-1:0] rq_idx_t;

    ////////////////////
    // processor ports

    typedef struct packed {
        logic                  en;
        logic [AXI_ADDR_W-1:0] addr;
    } ifetch_req_t;

    // store data is expected already placed on its byte lanes
    typedef struct packed {
        logic                  rd;
        logic                  wr;
        logic [AXI_ADDR_W-1:0] addr;
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_SIZE_W-1:0] size;
    } dmem_req_t;

    typedef struct packed {
        logic                  valid;
        logic [AXI_ADDR_W-1:0] addr;
        logic [AXI_DATA_W-1:0] data;
    } port_rsp_t;

    ////////////////////
    // between arbiter, queue and write buffer

    typedef struct packed {
        logic                  push;
        logic                  is_data;
        logic [AXI_ADDR_W-1:0] addr;
        logic [AXI_SIZE_W-1:0] size;
    } rd_req_t;

    typedef struct packed {
        logic                  valid;
        logic [AXI_ADDR_W-1:0] addr;
    } wr_pend_t;

endpackage

`default_nettype wire

// File: project.f
axi_pkg.sv
bridge_pkg.sv
read_arbiter.sv
read_queue.sv
write_buffer.sv
axi_bridge_top.sv
axi_bridge_sva.sv
tb_axi_bridge.sv

// File: read_arbiter.sv
/* read arbiter: alternating priority between fetch and data reads,
   store hazard check, queue push and both processor stalls */
`timescale 1ns/1ns
`default_nettype none

module read_arbiter
    import axi_pkg::*;
    import bridge_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  ifetch_req_t i_ifetch,
    input  dmem_req_t   i_dmem,
    input  logic        i_full,
    input  wr_pend_t    i_wr_pend,
    input  logic        i_wr_busy,
    output rd_req_t     o_rd_req,
    output logic        o_i_stall,
    output logic        o_d_stall
);

    localparam int WORD_ADDR_W = AXI_ADDR_W - AXI_BYTE_OFS_W;

    logic [WORD_ADDR_W-1:0] pend_word;
    logic                   i_hazard;
    logic                   d_hazard;
    logic                   i_ok;
    logic                   d_ok;
    logic                   pick_i;
    logic                   pick_d;
    // set when the last accepted read was a fetch
    logic                   last_was_i;

    ////////////////////
    // hazard against the pending store

    // compare at bus word granularity so sub-word stores also block
    assign pend_word = i_wr_pend.addr[AXI_ADDR_W-1:AXI_BYTE_OFS_W];
    assign i_hazard  = i_wr_pend.valid &&
                       (i_ifetch.addr[AXI_ADDR_W-1:AXI_BYTE_OFS_W] == pend_word);
    assign d_hazard  = i_wr_pend.valid &&
                       (i_dmem.addr[AXI_ADDR_W-1:AXI_BYTE_OFS_W] == pend_word);

    ////////////////////
    // selection

    assign i_ok = i_ifetch.en && !i_full && !i_hazard;
    assign d_ok = i_dmem.rd && !i_full && !d_hazard;

    // fetch wins a tie unless it won the previous one
    assign pick_i = i_ok && (!d_ok || !last_was_i);
    assign pick_d = d_ok && !pick_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_was_i <= 1'b0;
        end else if (pick_i || pick_d) begin
            last_was_i <= pick_i;
        end
    end

    always_comb begin
        o_rd_req.push    = pick_i || pick_d;
        o_rd_req.is_data = pick_d;
        o_rd_req.addr    = pick_d ? i_dmem.addr : i_ifetch.addr;
        o_rd_req.size    = pick_d ? i_dmem.size : SIZE_DWORD;
    end

    ////////////////////
    // stalls

    assign o_i_stall = i_ifetch.en && !pick_i;
    // a store waits while the buffer is held by an unfinished write
    assign o_d_stall = (i_dmem.rd && !pick_d) || (i_dmem.wr && i_wr_busy);

endmodule

`default_nettype wire

// File: read_queue.sv
/* in-order read queue: slot store, allocate, issue and retire pointers,
   AR issue by slot id and in-order delivery to the two ports */
`timescale 1ns/1ns
`default_nettype none

module read_queue
    import axi_pkg::*;
    import bridge_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  rd_req_t   i_rd_req,
    output logic      o_full,
    output axi_ar_t   o_ar,
    input  logic      i_arready,
    input  axi_r_t    i_r,
    output port_rsp_t o_i_rsp,
    output port_rsp_t o_d_rsp
);

    // pointers carry one extra wrap bit to tell full from empty
    logic [RQ_IDX_W:0]     alloc_ptr;
    logic [RQ_IDX_W:0]     issue_ptr;
    logic [RQ_IDX_W:0]     retire_ptr;
    rq_idx_t               alloc_idx;
    rq_idx_t               issue_idx;
    rq_idx_t               retire_idx;
    rq_idx_t               r_idx;

    // slot store
    logic [AXI_ADDR_W-1:0] slot_addr [RQ_DEPTH];
    logic [AXI_SIZE_W-1:0] slot_size [RQ_DEPTH];
    logic [AXI_DATA_W-1:0] slot_data [RQ_DEPTH];
    logic [RQ_DEPTH-1:0]   slot_is_data;
    logic [RQ_DEPTH-1:0]   slot_done;

    logic                  empty;
    logic                  ar_fire;
    logic                  head_hit;
    logic                  head_done;
    logic                  retire;
    logic [AXI_DATA_W-1:0] head_data;

    assign alloc_idx  = alloc_ptr[RQ_IDX_W-1:0];
    assign issue_idx  = issue_ptr[RQ_IDX_W-1:0];
    assign retire_idx = retire_ptr[RQ_IDX_W-1:0];
    assign r_idx      = i_r.id[RQ_IDX_W-1:0];

    assign empty  = (alloc_ptr == retire_ptr);
    assign o_full = (alloc_ptr[RQ_IDX_W] != retire_ptr[RQ_IDX_W]) &&
                    (alloc_idx == retire_idx);

    assign ar_fire = o_ar.valid && i_arready;

    // rready is tied high, so any R beat is taken
    assign head_hit  = i_r.valid && !empty && (r_idx == retire_idx);
    assign head_done = !empty && slot_done[retire_idx];
    assign retire    = head_hit || head_done;

    ////////////////////
    // pointers

    always_ff @(posedge clk) begin
        if (rst) begin
            alloc_ptr  <= '0;
            issue_ptr  <= '0;
            retire_ptr <= '0;
        end else begin
            if (i_rd_req.push) begin
                alloc_ptr <= alloc_ptr + 1'b1;
            end
            if (ar_fire) begin
                issue_ptr <= issue_ptr + 1'b1;
            end
            if (retire) begin
                retire_ptr <= retire_ptr + 1'b1;
            end
        end
    end

    ////////////////////
    // slot state

    // done marks a slot whose beat arrived before it became the head
    always_ff @(posedge clk) begin
        if (rst) begin
            slot_done <= '0;
        end else begin
            if (retire) begin
                slot_done[retire_idx] <= 1'b0;
            end
            if (i_r.valid && !head_hit) begin
                slot_done[r_idx] <= 1'b1;
            end
            if (i_rd_req.push) begin
                slot_done[alloc_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rd_req.push) begin
            slot_addr[alloc_idx]    <= i_rd_req.addr;
            slot_size[alloc_idx]    <= i_rd_req.size;
            slot_is_data[alloc_idx] <= i_rd_req.is_data;
        end
        // a head beat goes straight out and is not kept
        if (i_r.valid && !head_hit) begin
            slot_data[r_idx] <= i_r.data;
        end
    end

    ////////////////////
    // AR issue

    always_comb begin
        o_ar.valid = (issue_ptr != alloc_ptr);
        o_ar.id    = AXI_ID_W'(issue_idx);
        o_ar.addr  = slot_addr[issue_idx];
        o_ar.len   = '0;
        o_ar.size  = slot_size[issue_idx];
        o_ar.burst = AXI_BURST_INCR;
    end

    ////////////////////
    // delivery

    assign head_data = head_hit ? i_r.data : slot_data[retire_idx];

    always_comb begin
        o_i_rsp.valid = retire && !slot_is_data[retire_idx];
        o_i_rsp.addr  = slot_addr[retire_idx];
        o_i_rsp.data  = head_data;
        o_d_rsp.valid = retire && slot_is_data[retire_idx];
        o_d_rsp.addr  = slot_addr[retire_idx];
        o_d_rsp.data  = head_data;
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_axi_bridge \
    -f project.f -o sim_axi_bridge
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/sim_axi_bridge > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
exit 0

// File: tb_axi_bridge.sv
/* testbench for the processor to AXI3 bridge: clock, reset, reordering AXI memory model,
   directed test tasks, typed compare tasks and a cycle timeout */
`timescale 1ns/1ns
`default_nettype none

module tb_axi_bridge
    import axi_pkg::*;
    import bridge_pkg::*;
;

    localparam int TIMEOUT_CYCLES = 2000;

    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_ADDR_W-1:0] addr;
    } pend_rd_t;

    logic        clk;
    logic        rst;
    ifetch_req_t ifetch;
    dmem_req_t   dmem;
    port_rsp_t   rsp_i;
    port_rsp_t   rsp_d;
    logic        stall_i;
    logic        stall_d;
    axi_ar_t     ar;
    logic        arready;
    axi_r_t      r;
    logic        rready;
    axi_aw_t     aw;
    logic        awready;
    axi_w_t      w;
    logic        wready;
    axi_b_t      b;
    logic        bready;

    // memory model and its mirror, keyed by bus word address
    logic [AXI_DATA_W-1:0] mem [logic [AXI_ADDR_W-1:0]];
    logic [AXI_DATA_W-1:0] mirror [logic [AXI_ADDR_W-1:0]];
    pend_rd_t              ar_list [$];
    port_rsp_t             exp_i_q [$];
    port_rsp_t             exp_d_q [$];
    axi_ar_t               exp_ar_q [$];
    logic                  acc_types [$];

    logic                  hold_ar;
    logic                  hold_r;
    logic                  rev_r;
    logic                  aw_got;
    logic                  w_got;
    logic                  b_due;
    logic                  wr_open;
    logic [AXI_ADDR_W-1:0] aw_addr;
    axi_w_t                w_data;
    axi_w_t                exp_w;
    axi_aw_t               exp_aw;
    logic                  i_acc;
    logic                  d_acc;
    logic                  d_wacc;
    int                    cyc;
    int                    last_b_cyc;
    int                    last_ar_cyc;
    int                    alloc_cnt;
    logic [31:0]           seed;

    axi_bridge_top i_axi_bridge_top (
        .clk       (clk),
        .rst       (rst),
        .i_ifetch  (ifetch),
        .i_dmem    (dmem),
        .o_i_rsp   (rsp_i),
        .o_d_rsp   (rsp_d),
        .o_i_stall (stall_i),
        .o_d_stall (stall_d),
        .o_ar      (ar),
        .i_arready (arready),
        .i_r       (r),
        .o_rready  (rready),
        .o_aw      (aw),
        .i_awready (awready),
        .o_w       (w),
        .i_wready  (wready),
        .i_b       (b),
        .o_bready  (bready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // helpers

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // default contents depend on every address bit
    function automatic logic [AXI_DATA_W-1:0] fill_word(logic [AXI_ADDR_W-1:0] wa);
        return {wa ^ 32'h9e3779b9, wa * 32'h01000193};
    endfunction

    function automatic logic [AXI_DATA_W-1:0] mem_word(logic [AXI_ADDR_W-1:0] wa);
        return mem.exists(wa) ? mem[wa] : fill_word(wa);
    endfunction

    function automatic logic [AXI_DATA_W-1:0] mirror_word(logic [AXI_ADDR_W-1:0] wa);
        return mirror.exists(wa) ? mirror[wa] : fill_word(wa);
    endfunction

    // size mask moved onto the lanes named by the low address bits
    function automatic logic [AXI_STRB_W-1:0] strb_for(logic [AXI_SIZE_W-1:0] size,
                                                      logic [AXI_ADDR_W-1:0] addr);
        case (size)
            3'd0:    return 8'h01 << addr[2:0];
            3'd1:    return 8'h03 << addr[2:0];
            3'd2:    return 8'h0f << addr[2:0];
            default: return 8'hff;
        endcase
    endfunction

    function automatic logic [AXI_DATA_W-1:0] merge_bytes(logic [AXI_DATA_W-1:0] old_w,
                                                          logic [AXI_DATA_W-1:0] new_w,
                                                          logic [AXI_STRB_W-1:0] strb);
        logic [AXI_DATA_W-1:0] res;
        res = old_w;
        for (int k = 0; k < AXI_STRB_W; k++) begin
            if (strb[k]) begin
                res[k*8 +: 8] = new_w[k*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_failure(string msg);
        $display("%s at time %0t", msg, $time);
        stop_run();
    endtask

    ////////////////////
    // compare tasks

    task automatic check_rsp(string name, port_rsp_t got, port_rsp_t exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_ar(axi_ar_t got, axi_ar_t exp);
        if (got !== exp) begin
            $display("ERROR t=%0t o_ar got %h expected %h", $time, got, exp);
            stop_run();
        end
    endtask

    // any id is legal while only one write is in flight
    task automatic check_aw(axi_aw_t got, axi_aw_t exp);
        axi_aw_t cmp;
        cmp    = got;
        cmp.id = exp.id;
        if (cmp !== exp) begin
            $display("ERROR t=%0t o_aw got %h expected %h", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic check_w(axi_w_t got, axi_w_t exp);
        if (got !== exp) begin
            $display("ERROR t=%0t o_w got %h expected %h", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    ////////////////////
    // AXI memory model and per-cycle bookkeeping

    task automatic model_drive();
        logic [31:0] rnd;
        int          idx;
        pend_rd_t    p;
        r       = '0;
        b       = '0;
        arready = !hold_ar;
        if (b_due) begin
            mem[aw_addr >> 3] = merge_bytes(mem_word(aw_addr >> 3), w_data.data, w_data.strb);
            b.valid    = 1'b1;
            b_due      = 1'b0;
            wr_open    = 1'b0;
            last_b_cyc = cyc;
        end
        if (!hold_r && ar_list.size() > 0) begin
            rnd = lcg_next();
            // random gaps give varying latency
            if (rev_r || rnd[5:4] != 2'd0) begin
                idx = rev_r ? ar_list.size() - 1 : int'(rnd[15:8]) % ar_list.size();
                p   = ar_list[idx];
                ar_list.delete(idx);
                r.valid = 1'b1;
                r.id    = p.id;
                r.data  = mem_word(p.addr >> 3);
                r.last  = 1'b1;
            end
        end
    endtask

    task automatic push_read(logic is_data, logic [AXI_ADDR_W-1:0] addr,
                             logic [AXI_SIZE_W-1:0] size);
        port_rsp_t rsp;
        axi_ar_t   exp;
        rsp = '{valid: 1'b1, addr: addr, data: mirror_word(addr >> 3)};
        exp = '{valid: 1'b1, id: AXI_ID_W'(alloc_cnt % RQ_DEPTH), addr: addr,
                len: '0, size: size, burst: AXI_BURST_INCR};
        alloc_cnt++;
        exp_ar_q.push_back(exp);
        acc_types.push_back(is_data);
        if (is_data) begin
            exp_d_q.push_back(rsp);
        end else begin
            exp_i_q.push_back(rsp);
        end
    endtask

    task automatic sample();
        logic [AXI_STRB_W-1:0] strb;
        check_bit("o_rready", rready, 1'b1);
        check_bit("o_bready", bready, 1'b1);
        i_acc  = ifetch.en && !stall_i;
        d_acc  = dmem.rd && !stall_d;
        d_wacc = dmem.wr && !stall_d;
        if (i_acc && d_acc) begin
            report_failure("two reads were accepted in one cycle");
        end
        if (ar.valid && arready) begin
            if (exp_ar_q.size() == 0) begin
                report_failure("an AR request went out with no accepted read behind it");
            end
            check_ar(ar, exp_ar_q.pop_front());
            ar_list.push_back('{id: ar.id, addr: ar.addr});
            last_ar_cyc = cyc;
        end
        if (aw.valid && awready) begin
            check_aw(aw, exp_aw);
            aw_addr = aw.addr;
            aw_got  = 1'b1;
        end
        if (w.valid && wready) begin
            check_w(w, exp_w);
            w_data = w;
            w_got  = 1'b1;
        end
        // B follows one cycle after both halves of a write
        if (aw_got && w_got) begin
            b_due  = 1'b1;
            aw_got = 1'b0;
            w_got  = 1'b0;
        end
        if (rsp_i.valid) begin
            if (exp_i_q.size() == 0) begin
                report_failure("an instruction response came with no read pending");
            end
            check_rsp("o_i_rsp", rsp_i, exp_i_q.pop_front());
        end
        if (rsp_d.valid) begin
            if (exp_d_q.size() == 0) begin
                report_failure("a data response came with no read pending");
            end
            check_rsp("o_d_rsp", rsp_d, exp_d_q.pop_front());
        end
        if (i_acc) begin
            push_read(1'b0, ifetch.addr, SIZE_DWORD);
        end
        if (d_acc) begin
            push_read(1'b1, dmem.addr, dmem.size);
        end
        if (d_wacc) begin
            strb   = strb_for(dmem.size, dmem.addr);
            exp_w  = '{valid: 1'b1, data: dmem.data, strb: strb, last: 1'b1};
            exp_aw = '{valid: 1'b1, id: '0, addr: dmem.addr, len: '0, size: dmem.size,
                       burst: AXI_BURST_INCR};
            mirror[dmem.addr >> 3] = merge_bytes(mirror_word(dmem.addr >> 3), dmem.data, strb);
            wr_open = 1'b1;
        end
    endtask

    // one clock from falling edge to falling edge
    task automatic cycle();
        model_drive();
        #1;
        sample();
        cyc++;
        if (cyc > TIMEOUT_CYCLES) begin
            $display("timeout: the run went past %0d cycles", TIMEOUT_CYCLES);
            stop_run();
        end
        @(negedge clk);
    endtask

    task automatic wait_idle();
        while (exp_i_q.size() > 0 || exp_d_q.size() > 0 || wr_open || b_due) begin
            cycle();
        end
    endtask

    ////////////////////
    // request tasks

    task automatic issue_write(logic [AXI_ADDR_W-1:0] addr, logic [AXI_DATA_W-1:0] data,
                               logic [AXI_SIZE_W-1:0] size);
        dmem = '{rd: 1'b0, wr: 1'b1, addr: addr, data: data, size: size};
        do begin
            cycle();
        end while (!d_wacc);
        dmem = '0;
    endtask

    task automatic issue_dread(logic [AXI_ADDR_W-1:0] addr);
        dmem = '{rd: 1'b1, wr: 1'b0, addr: addr, data: '0, size: SIZE_DWORD};
        do begin
            cycle();
        end while (!d_acc);
        dmem = '0;
    endtask

    task automatic issue_fetch(logic [AXI_ADDR_W-1:0] addr);
        ifetch = '{en: 1'b1, addr: addr};
        do begin
            cycle();
        end while (!i_acc);
        ifetch = '0;
    endtask

    ////////////////////
    // directed tests

    task automatic test_write_then_read();
        issue_write(32'h100, 64'h1122_3344_5566_7788, 3'd3);
        issue_dread(32'h100);
        wait_idle();
        if (last_ar_cyc <= last_b_cyc) begin
            report_failure("the read went out on AR before the write's B response");
        end
    endtask

    task automatic test_reverse_fetch();
        hold_r = 1'b1;
        for (int k = 0; k < 4; k++) begin
            issue_fetch(32'h200 + 32'(k * 8));
        end
        while (ar_list.size() < 4) begin
            cycle();
        end
        rev_r  = 1'b1;
        hold_r = 1'b0;
        wait_idle();
        rev_r  = 1'b0;
    endtask

    task automatic test_alternate();
        logic [AXI_ADDR_W-1:0] ia;
        logic [AXI_ADDR_W-1:0] da;
        ia = 32'h400;
        da = 32'h800;
        acc_types.delete();
        while (acc_types.size() < 12) begin
            ifetch = '{en: 1'b1, addr: ia};
            dmem   = '{rd: 1'b1, wr: 1'b0, addr: da, data: '0, size: SIZE_DWORD};
            cycle();
            if (i_acc) ia += 8;
            if (d_acc) da += 8;
        end
        ifetch = '0;
        dmem   = '0;
        wait_idle();
        for (int k = 1; k < 12; k++) begin
            if (acc_types[k] == acc_types[k-1]) begin
                report_failure("accepted reads did not alternate between the two ports");
            end
        end
    endtask

    task automatic test_queue_full();
        int                    count;
        logic                  seen;
        logic [AXI_ADDR_W-1:0] fa;
        count   = 0;
        seen    = 1'b0;
        fa      = 32'h1000;
        hold_ar = 1'b1;
        while (!seen) begin
            ifetch = '{en: 1'b1, addr: fa};
            cycle();
            if (i_acc) begin
                count++;
                fa += 8;
            end else if (stall_i) begin
                seen = 1'b1;
            end
        end
        ifetch = '0;
        if (count != RQ_DEPTH) begin
            $display("ERROR t=%0t accepted reads got %0d expected %0d", $time, count, RQ_DEPTH);
            stop_run();
        end
        hold_ar = 1'b0;
        wait_idle();
    endtask

    task automatic test_subword_writes();
        issue_write(32'h1803, 64'hffff_ffff_ab00_0000, 3'd0);
        issue_write(32'h1806, 64'hcdef_1234_5678_9abc, 3'd1);
        issue_write(32'h180c, 64'h0bad_cafe_dead_beef, 3'd2);
        issue_dread(32'h1800);
        issue_dread(32'h1808);
        wait_idle();
    endtask

    task automatic test_random_mix();
        logic [31:0]           rnd;
        logic [AXI_ADDR_W-1:0] a;
        logic [AXI_SIZE_W-1:0] size;
        logic [2:0]            ofs;
        repeat (24) begin
            rnd  = lcg_next();
            a    = 32'h2000 + {26'd0, rnd[4:2], 3'd0};
            size = {1'b0, rnd[9:8]};
            ofs  = (rnd[12:10] >> size) << size;
            if (rnd[0]) begin
                issue_write(a + {29'd0, ofs}, {lcg_next(), lcg_next()}, size);
            end else if (rnd[1]) begin
                issue_fetch(a);
            end else begin
                issue_dread(a);
            end
            wait_idle();
        end
    endtask

    initial begin
        rst       = 1'b1;
        ifetch    = '0;
        dmem      = '0;
        arready   = 1'b0;
        r         = '0;
        awready   = 1'b1;
        wready    = 1'b1;
        b         = '0;
        hold_ar   = 1'b0;
        hold_r    = 1'b0;
        rev_r     = 1'b0;
        aw_got    = 1'b0;
        w_got     = 1'b0;
        b_due     = 1'b0;
        wr_open   = 1'b0;
        aw_addr   = '0;
        w_data    = '0;
        exp_w     = '0;
        exp_aw    = '0;
        cyc       = 0;
        alloc_cnt = 0;
        seed      = 32'he76af80d;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_write_then_read();
        test_reverse_fetch();
        test_alternate();
        test_queue_full();
        test_subword_writes();
        test_random_mix();

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: write_buffer.sv
/* single-entry store buffer: AW, W and B sequencing and byte strobes */
`timescale 1ns/1ns
`default_nettype none

module write_buffer
    import axi_pkg::*;
    import bridge_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  dmem_req_t i_dmem,
    output wr_pend_t  o_wr_pend,
    output logic      o_wr_busy,
    output axi_aw_t   o_aw,
    input  logic      i_awready,
    output axi_w_t    o_w,
    input  logic      i_wready,
    input  axi_b_t    i_b
);

    logic                      buf_valid;
    logic                      aw_sent;
    logic                      w_sent;
    logic [AXI_ADDR_W-1:0]     buf_addr;
    logic [AXI_DATA_W-1:0]     buf_data;
    logic [AXI_SIZE_W-1:0]     buf_size;

    logic                      b_done;
    logic                      accept;
    logic [AXI_STRB_W-1:0]     size_mask;
    logic [AXI_BYTE_OFS_W-1:0] byte_ofs;

    // bready is tied high
    assign b_done    = buf_valid && i_b.valid;
    assign accept    = i_dmem.wr && (!buf_valid || b_done);
    assign o_wr_busy = buf_valid && !b_done;

    ////////////////////
    // buffer and channel flags

    always_ff @(posedge clk) begin
        if (rst) begin
            buf_valid <= 1'b0;
            aw_sent   <= 1'b0;
            w_sent    <= 1'b0;
        end else if (accept) begin
            buf_valid <= 1'b1;
            aw_sent   <= 1'b0;
            w_sent    <= 1'b0;
        end else begin
            if (b_done) begin
                buf_valid <= 1'b0;
            end
            if (o_aw.valid && i_awready) begin
                aw_sent <= 1'b1;
            end
            if (o_w.valid && i_wready) begin
                w_sent <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_addr <= i_dmem.addr;
            buf_data <= i_dmem.data;
            buf_size <= i_dmem.size;
        end
    end

    assign o_wr_pend.valid = buf_valid;
    assign o_wr_pend.addr  = buf_addr;

    ////////////////////
    // strobes

    assign byte_ofs = buf_addr[AXI_BYTE_OFS_W-1:0];

    always_comb begin
        case (buf_size)
            3'd0:    size_mask = AXI_STRB_W'(8'h01);
            3'd1:    size_mask = AXI_STRB_W'(8'h03);
            3'd2:    size_mask = AXI_STRB_W'(8'h0f);
            default: size_mask = '1;
        endcase
    end

    always_comb begin
        o_aw.valid = buf_valid && !aw_sent;
        o_aw.id    = '0;
        o_aw.addr  = buf_addr;
        o_aw.len   = '0;
        o_aw.size  = buf_size;
        o_aw.burst = AXI_BURST_INCR;

        o_w.valid  = buf_valid && !w_sent;
        o_w.data   = buf_data;
        // full-word stores use every lane regardless of offset
        o_w.strb   = (buf_size < SIZE_DWORD) ? (size_mask << byte_ofs) : size_mask;
        o_w.last   = 1'b1;
    end

endmodule

`default_nettype wire
